//--- flist.f
verilog/rv32i_isa_pkg.sv
verilog/decode_pkg.sv
verilog/decode_if.sv
verilog/instr_classifier.sv
verilog/imm_decoder.sv
verilog/next_pc_unit.sv
verilog/decode_stage.sv
tests/decode_stage_tb.sv

//--- tests/decode_stage_tb.sv
module decode_stage_tb import rv32i_isa_pkg::*, decode_pkg::*; ();

  localparam int num_tests = 19;
  localparam int max_cycles = 5 + 2 * num_tests + 20;
  localparam instr_t idle_instr = 32'hffff_ffff;
  localparam word_t idle_pc = 32'hffff_0000;

  typedef struct packed {
    logic [63:0] name;
    instr_t      instr;
    word_t       pc;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       next_pc;
    alu_op_t     alu_op;
    mem_op_t     mem_op;
    reg_idx_t    rd;
    word_t       op_a;
    word_t       op_b;
    word_t       mem_addr;
    logic        instr_valid;
  } vector_t;

  logic     clk;
  logic     reset;
  logic     fetch_valid;
  instr_t   instr;
  word_t    fetch_pc;
  word_t    reg_rs1;
  word_t    reg_rs2;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     out_valid;
  word_t    next_pc;
  alu_op_t  alu_op;
  mem_op_t  mem_op;
  reg_idx_t rd;
  word_t    op_a;
  word_t    op_b;
  word_t    mem_addr;
  logic     instr_valid;

  vector_t tbl [num_tests];
  int      pending;
  int      last;
  int      cycles;

  decode_stage dut_i (.*);

  // register file model that includes x0
  function automatic word_t reg_value(input reg_idx_t idx);
    return idx * 32'h0101_0101 + 32'h7000_0000;
  endfunction

  assign reg_rs1 = reg_value(rs1);
  assign reg_rs2 = reg_value(rs2);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) abort_run("run did not finish within the cycle limit");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [63:0] name, input string what, input word_t exp,
                            input word_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %0s %s expected %h actual %h", name, what, exp, act));
  endtask

  task automatic check_reg(input logic [63:0] name, input string what, input reg_idx_t exp,
                           input reg_idx_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %0s %s expected %0d actual %0d", name, what, exp, act));
  endtask

  task automatic check_alu(input logic [63:0] name, input alu_op_t exp, input alu_op_t act);
    if (act !== exp) abort_run($sformatf("ERR %0s alu_op expected %s actual %s", name, exp.name(),
                                         act.name()));
  endtask

  task automatic check_mem(input logic [63:0] name, input mem_op_t exp, input mem_op_t act);
    if (act !== exp) abort_run($sformatf("ERR %0s mem_op expected %s actual %s", name, exp.name(),
                                         act.name()));
  endtask

  task automatic check_bit(input logic [63:0] name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) abort_run($sformatf("ERR %0s %s expected %b actual %b", name, what, exp, act));
  endtask

  task automatic check_outputs(input int i);
    check_word(tbl[i].name, "next_pc", tbl[i].next_pc, next_pc);
    check_alu(tbl[i].name, tbl[i].alu_op, alu_op);
    check_mem(tbl[i].name, tbl[i].mem_op, mem_op);
    check_reg(tbl[i].name, "rd", tbl[i].rd, rd);
    check_word(tbl[i].name, "op_a", tbl[i].op_a, op_a);
    check_word(tbl[i].name, "op_b", tbl[i].op_b, op_b);
    check_word(tbl[i].name, "mem_addr", tbl[i].mem_addr, mem_addr);
    check_bit(tbl[i].name, "instr_valid", tbl[i].instr_valid, instr_valid);
  endtask

  // one clock cycle with or without a driven entry
  task automatic run_cycle(input logic drive, input int i);
    @(posedge clk);
    fetch_valid <= drive;
    if (drive) begin
      instr    <= tbl[i].instr;
      fetch_pc <= tbl[i].pc;
    end else begin
      // junk that must not be captured
      instr    <= idle_instr;
      fetch_pc <= idle_pc;
    end
    @(negedge clk);
    if (out_valid !== 1'b1 && pending >= 0) abort_run("out_valid missing after a driven entry");
    if (out_valid !== 1'b0 && pending < 0) abort_run("out_valid high without a driven entry");
    if (pending >= 0) begin
      check_outputs(pending);
      last = pending;
    end else if (last >= 0) begin
      // registered outputs hold while idle
      check_outputs(last);
    end else begin
      // reset values before the first entry
      check_word("reset", "next_pc", '0, next_pc);
      check_alu("reset", alu_none, alu_op);
      check_mem("reset", mem_none, mem_op);
    end
    if (drive) begin
      check_reg(tbl[i].name, "rs1", tbl[i].rs1, rs1);
      check_reg(tbl[i].name, "rs2", tbl[i].rs2, rs2);
    end
    pending = drive ? i : -1;
  endtask

  task automatic load_table();
    tbl[0]  = '{"add", 32'h002081b3, 32'h100, 5'd1, 5'd2, 32'h104,
                alu_add, mem_none, 5'd3, 32'h71010101, 32'h72020202, 32'h71010101, 1'b1};
    tbl[1]  = '{"sub", 32'h402081b3, 32'h104, 5'd1, 5'd2, 32'h108,
                alu_sub, mem_none, 5'd3, 32'h71010101, 32'h72020202, 32'h71010101, 1'b1};
    tbl[2]  = '{"sra", 32'h402fd2b3, 32'h108, 5'd31, 5'd2, 32'h10c,
                alu_sra, mem_none, 5'd5, 32'h8f1f1f1f, 32'h72020202, 32'h8f1f1f1f, 1'b1};
    tbl[3]  = '{"sltu", 32'h01f0b233, 32'h10c, 5'd1, 5'd31, 32'h110,
                alu_sltu, mem_none, 5'd4, 32'h71010101, 32'h8f1f1f1f, 32'h71010101, 1'b1};
    tbl[4]  = '{"addi", 32'hffb08313, 32'h200, 5'd1, 5'd27, 32'h204,
                alu_add, mem_none, 5'd6, 32'h71010101, 32'hfffffffb, 32'h710100fc, 1'b1};
    tbl[5]  = '{"slli", 32'h00311393, 32'h204, 5'd2, 5'd3, 32'h208,
                alu_sll, mem_none, 5'd7, 32'h72020202, 32'h00000003, 32'h72020205, 1'b1};
    tbl[6]  = '{"srai", 32'h404fd413, 32'h208, 5'd31, 5'd4, 32'h20c,
                alu_sra, mem_none, 5'd8, 32'h8f1f1f1f, 32'h00000404, 32'h8f1f2323, 1'b1};
    tbl[7]  = '{"lui", 32'h123454b7, 32'h300, 5'd8, 5'd3, 32'h304,
                alu_add, mem_none, 5'd9, 32'h12345000, 32'h00000000, 32'h8a3c5808, 1'b1};
    tbl[8]  = '{"auipc", 32'hfffff517, 32'h304, 5'd31, 5'd31, 32'h308,
                alu_add, mem_none, 5'd10, 32'h00000304, 32'hfffff000, 32'h8f1f0f1f, 1'b1};
    tbl[9]  = '{"lw", 32'h00812583, 32'h400, 5'd2, 5'd8, 32'h404,
                alu_none, mem_lw, 5'd11, 32'h00000000, 32'h00000000, 32'h7202020a, 1'b1};
    tbl[10] = '{"lbu", 32'h001fc603, 32'h404, 5'd31, 5'd1, 32'h408,
                alu_none, mem_lbu, 5'd12, 32'h00000000, 32'h00000000, 32'h8f1f1f20, 1'b1};
    tbl[11] = '{"sh_neg", 32'hfe209d23, 32'h408, 5'd1, 5'd2, 32'h40c,
                alu_none, mem_sh, 5'd0, 32'h71010101, 32'h72020202, 32'h710100fb, 1'b1};
    // equal indices read equal values, so beq is taken
    tbl[12] = '{"beq_tkn", 32'h00108863, 32'h500, 5'd1, 5'd1, 32'h510,
                alu_none, mem_none, 5'd0, 32'h00000000, 32'h00000000, 32'h71010111, 1'b1};
    tbl[13] = '{"blt_tkn", 32'hfe1fc0e3, 32'h510, 5'd31, 5'd1, 32'h4f0,
                alu_none, mem_none, 5'd0, 32'h00000000, 32'h00000000, 32'h8f1f1eff, 1'b1};
    tbl[14] = '{"bgeu_nt", 32'h01f0f463, 32'h514, 5'd1, 5'd31, 32'h518,
                alu_none, mem_none, 5'd0, 32'h00000000, 32'h00000000, 32'h71010109, 1'b1};
    tbl[15] = '{"jal", 32'h001000ef, 32'h600, 5'd0, 5'd1, 32'he00,
                alu_add, mem_none, 5'd1, 32'h00000600, 32'h00000004, 32'h70000800, 1'b1};
    tbl[16] = '{"jalr", 32'h005100e7, 32'h604, 5'd2, 5'd5, 32'h72020206,
                alu_add, mem_none, 5'd1, 32'h00000604, 32'h00000004, 32'h72020207, 1'b1};
    tbl[17] = '{"bad_low", 32'h002081b1, 32'h700, 5'd1, 5'd2, 32'h704,
                alu_none, mem_none, 5'd3, 32'h00000000, 32'h00000000, 32'h71010101, 1'b0};
    tbl[18] = '{"csrrw", 32'h300092f3, 32'h704, 5'd1, 5'd0, 32'h708,
                alu_none, mem_none, 5'd5, 32'h00000000, 32'h00000000, 32'h71010101, 1'b0};
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    fetch_valid = 1'b0;
    instr = '0;
    fetch_pc = '0;
    cycles = 0;
    pending = -1;
    last = -1;
    load_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    run_cycle(1'b0, 0);
    for (int i = 0; i < num_tests; i++) begin
      run_cycle(1'b1, i);
      // idle gap after every third entry
      if (i % 3 == 2) run_cycle(1'b0, 0);
    end
    run_cycle(1'b0, 0);
    run_cycle(1'b0, 0);
    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog/decode_if.sv
interface decode_if import rv32i_isa_pkg::*, decode_pkg::*; ();

  op_class_t    op_class;
  alu_op_t      alu_op;
  mem_op_t      mem_op;
  branch_cond_t branch_cond;
  reg_idx_t     rd;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  word_t        imm;

  modport classifier (
    output op_class,
    output alu_op,
    output mem_op,
    output branch_cond,
    output rd,
    output rs1,
    output rs2
  );

  modport imm_dec (
    input  op_class,
    output imm
  );

  modport consumer (
    input op_class,
    input alu_op,
    input mem_op,
    input branch_cond,
    input rd,
    input rs1,
    input rs2,
    input imm
  );

endinterface

//--- verilog/decode_pkg.sv
package decode_pkg;

  typedef enum logic [3:0] {
    op_reg,
    op_imm,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_load,
    op_store,
    op_illegal
  } op_class_t;

  typedef enum logic [3:0] {
    alu_none,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [3:0] {
    mem_none,
    mem_lb,
    mem_lh,
    mem_lw,
    mem_lbu,
    mem_lhu,
    mem_sb,
    mem_sh,
    mem_sw
  } mem_op_t;

  typedef enum logic [2:0] {
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_cond_t;

endpackage

//--- verilog/decode_stage.sv
module decode_stage import rv32i_isa_pkg::*, decode_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     fetch_valid,
  input  instr_t   instr,
  input  word_t    fetch_pc,
  input  word_t    reg_rs1,
  input  word_t    reg_rs2,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     out_valid,
  output word_t    next_pc,
  output alu_op_t  alu_op,
  output mem_op_t  mem_op,
  output reg_idx_t rd,
  output word_t    op_a,
  output word_t    op_b,
  output word_t    mem_addr,
  output logic     instr_valid
);

  decode_if dec_if ();

  word_t   next_pc_d;
  word_t   op_a_d;
  word_t   op_b_d;
  alu_op_t alu_op_d;

  instr_classifier classifier_i (.instr(instr), .dec(dec_if.classifier));
  imm_decoder      imm_dec_i    (.instr(instr), .dec(dec_if.imm_dec));

  next_pc_unit npc_i (
    .fetch_pc(fetch_pc),
    .reg_rs1 (reg_rs1),
    .reg_rs2 (reg_rs2),
    .dec     (dec_if.consumer),
    .next_pc (next_pc_d)
  );

  // register file is read in the decode cycle
  assign rs1 = dec_if.rs1;
  assign rs2 = dec_if.rs2;

  always_comb begin
    op_a_d   = '0;
    op_b_d   = '0;
    alu_op_d = alu_none;
    case (dec_if.op_class)
      op_reg: begin
        op_a_d   = reg_rs1;
        op_b_d   = reg_rs2;
        alu_op_d = dec_if.alu_op;
      end
      op_imm: begin
        op_a_d   = reg_rs1;
        op_b_d   = dec_if.imm;
        alu_op_d = dec_if.alu_op;
      end
      op_lui: begin
        op_a_d   = dec_if.imm;
        alu_op_d = alu_add;
      end
      op_auipc: begin
        op_a_d   = fetch_pc;
        op_b_d   = dec_if.imm;
        alu_op_d = alu_add;
      end
      // link value, pc + 4
      op_jal, op_jalr: begin
        op_a_d   = fetch_pc;
        op_b_d   = instr_bytes;
        alu_op_d = alu_add;
      end
      op_store: begin
        op_a_d = reg_rs1;
        op_b_d = reg_rs2;
      end
      default: alu_op_d = alu_none;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      next_pc   <= '0;
      alu_op    <= alu_none;
      mem_op    <= mem_none;
    end else begin
      out_valid <= fetch_valid;
      if (fetch_valid) begin
        next_pc <= next_pc_d;
        alu_op  <= alu_op_d;
        mem_op  <= dec_if.mem_op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      rd          <= dec_if.rd;
      op_a        <= op_a_d;
      op_b        <= op_b_d;
      mem_addr    <= reg_rs1 + dec_if.imm;
      instr_valid <= dec_if.op_class != op_illegal;
    end
  end

endmodule

//--- verilog/imm_decoder.sv
module imm_decoder import rv32i_isa_pkg::*, decode_pkg::*; (
  input instr_t     instr,
  decode_if.imm_dec dec
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // format follows from the class
  always_comb begin
    case (dec.op_class)
      op_imm, op_load, op_jalr: dec.imm = imm_i;
      op_store:                 dec.imm = imm_s;
      op_branch:                dec.imm = imm_b;
      op_lui, op_auipc:         dec.imm = imm_u;
      op_jal:                   dec.imm = imm_j;
      default:                  dec.imm = '0;
    endcase
  end

endmodule

//--- verilog/instr_classifier.sv
module instr_classifier import rv32i_isa_pkg::*, decode_pkg::*; (
  input instr_t        instr,
  decode_if.classifier dec
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    low_ok;
  logic    imm_ok;
  logic    reg_ok;
  alu_op_t alu_f3;

  assign opcode = instr[6:2];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign low_ok = instr[1:0] == opc_low_bits;

  // shifts by immediate carry funct7 in the upper imm bits
  assign imm_ok = (funct3 == f3_sll) ? (funct7 == funct7_base) :
                  (funct3 == f3_sr)  ? (funct7 == funct7_base || funct7 == funct7_alt) :
                  1'b1;
  assign reg_ok = (funct7 == funct7_base) ||
                  (funct7 == funct7_alt && (funct3 == f3_add || funct3 == f3_sr));

  always_comb begin
    case (funct3)
      f3_add:  alu_f3 = alu_add;
      f3_sll:  alu_f3 = alu_sll;
      f3_slt:  alu_f3 = alu_slt;
      f3_sltu: alu_f3 = alu_sltu;
      f3_xor:  alu_f3 = alu_xor;
      f3_sr:   alu_f3 = (funct7 == funct7_alt) ? alu_sra : alu_srl;
      f3_or:   alu_f3 = alu_or;
      default: alu_f3 = alu_and;
    endcase
  end

  always_comb begin
    dec.op_class    = op_illegal;
    dec.alu_op      = alu_none;
    dec.mem_op      = mem_none;
    dec.branch_cond = br_eq;
    if (low_ok) begin
      case (opcode)
        opc_lui:   dec.op_class = op_lui;
        opc_auipc: dec.op_class = op_auipc;
        opc_jal:   dec.op_class = op_jal;
        opc_jalr: begin
          if (funct3 == 3'b000) dec.op_class = op_jalr;
        end
        opc_branch: begin
          // funct3 010 and 011 are unused
          if (funct3[2:1] != 2'b01) dec.op_class = op_branch;
          case (funct3)
            3'b001:  dec.branch_cond = br_ne;
            3'b100:  dec.branch_cond = br_lt;
            3'b101:  dec.branch_cond = br_ge;
            3'b110:  dec.branch_cond = br_ltu;
            3'b111:  dec.branch_cond = br_geu;
            default: dec.branch_cond = br_eq;
          endcase
        end
        opc_load: begin
          case (funct3)
            3'b000:  dec.mem_op = mem_lb;
            3'b001:  dec.mem_op = mem_lh;
            3'b010:  dec.mem_op = mem_lw;
            3'b100:  dec.mem_op = mem_lbu;
            3'b101:  dec.mem_op = mem_lhu;
            default: dec.mem_op = mem_none;
          endcase
          if (dec.mem_op != mem_none) dec.op_class = op_load;
        end
        opc_store: begin
          case (funct3)
            3'b000:  dec.mem_op = mem_sb;
            3'b001:  dec.mem_op = mem_sh;
            3'b010:  dec.mem_op = mem_sw;
            default: dec.mem_op = mem_none;
          endcase
          if (dec.mem_op != mem_none) dec.op_class = op_store;
        end
        opc_op_imm: begin
          if (imm_ok) begin
            dec.op_class = op_imm;
            dec.alu_op   = alu_f3;
          end
        end
        opc_op: begin
          if (reg_ok) begin
            dec.op_class = op_reg;
            dec.alu_op   = (funct3 == f3_add && funct7 == funct7_alt) ? alu_sub : alu_f3;
          end
        end
        default: dec.op_class = op_illegal;
      endcase
    end
  end

  // no destination for branches and stores
  assign dec.rd  = (dec.op_class == op_branch || dec.op_class == op_store) ? '0 : instr[11:7];
  assign dec.rs1 = instr[19:15];
  assign dec.rs2 = instr[24:20];

endmodule

//--- verilog/next_pc_unit.sv
module next_pc_unit import rv32i_isa_pkg::*, decode_pkg::*; (
  input  word_t      fetch_pc,
  input  word_t      reg_rs1,
  input  word_t      reg_rs2,
  decode_if.consumer dec,
  output word_t      next_pc
);

  logic  taken;
  word_t seq_pc;
  word_t jump_target;
  word_t jalr_target;

  always_comb begin
    case (dec.branch_cond)
      br_eq:   taken = reg_rs1 == reg_rs2;
      br_ne:   taken = reg_rs1 != reg_rs2;
      br_lt:   taken = $signed(reg_rs1) < $signed(reg_rs2);
      br_ge:   taken = $signed(reg_rs1) >= $signed(reg_rs2);
      br_ltu:  taken = reg_rs1 < reg_rs2;
      br_geu:  taken = reg_rs1 >= reg_rs2;
      default: taken = 1'b0;
    endcase
  end

  assign seq_pc      = fetch_pc + instr_bytes;
  assign jump_target = fetch_pc + dec.imm;
  // register relative, low bit dropped
  assign jalr_target = (reg_rs1 + dec.imm) & jalr_align_mask;

  always_comb begin
    case (dec.op_class)
      op_jal:    next_pc = jump_target;
      op_jalr:   next_pc = jalr_target;
      op_branch: next_pc = taken ? jump_target : seq_pc;
      default:   next_pc = seq_pc;
    endcase
  end

endmodule

//--- verilog/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes, instruction bits 6:2
  localparam opcode_t opc_lui    = 5'b01101;
  localparam opcode_t opc_auipc  = 5'b00101;
  localparam opcode_t opc_jal    = 5'b11011;
  localparam opcode_t opc_jalr   = 5'b11001;
  localparam opcode_t opc_branch = 5'b11000;
  localparam opcode_t opc_load   = 5'b00000;
  localparam opcode_t opc_store  = 5'b01000;
  localparam opcode_t opc_op_imm = 5'b00100;
  localparam opcode_t opc_op     = 5'b01100;

  // anything else is a compressed encoding
  localparam logic [1:0] opc_low_bits = 2'b11;

  // alu funct3 values, shared by op and op_imm
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // alt selects sub and sra
  localparam funct7_t funct7_base = 7'b0000000;
  localparam funct7_t funct7_alt  = 7'b0100000;

  localparam word_t instr_bytes = 32'd4;

  // jalr target has bit 0 cleared
  localparam word_t jalr_align_mask = 32'hffff_fffe;

endpackage
